/* hw/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes, full 7-bit field
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_system = 7'b1110011;

  localparam logic [6:0] funct7_base   = 7'b0000000;
  localparam logic [6:0] funct7_alt    = 7'b0100000;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  // alu funct3
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // load/store width funct3
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  localparam word_t instr_bytes = 4;

endpackage

`default_nettype wire

/* hw/decode_pkg.sv */
`default_nettype none

package decode_pkg;

  typedef enum logic [3:0] {
    cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch, cls_load,
    cls_store, cls_op_imm, cls_op, cls_system, cls_illegal
  } instr_class_t;

  typedef enum logic [4:0] {
    alu_none,
    alu_add, alu_sub, alu_xor, alu_or, alu_and,
    alu_sll, alu_slt, alu_sltu, alu_srl, alu_sra,
    // M extension
    alu_mul, alu_mulh, alu_mulhsu, alu_mulhu,
    alu_div, alu_divu, alu_rem, alu_remu
  } alu_op_t;

  typedef enum logic [3:0] {
    mem_none,
    mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu,
    mem_sb, mem_sh, mem_sw
  } mem_op_t;

  typedef enum logic [1:0] {
    sys_none, sys_ecall, sys_ebreak
  } sys_op_t;

  // encodings follow the branch funct3 field
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } branch_cond_t;

endpackage

`default_nettype wire

/* hw/instr_classifier.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_classifier (
  input  rv_isa_pkg::word_t        instr,
  output decode_pkg::instr_class_t instr_class,
  output decode_pkg::alu_op_t      alu_op,
  output decode_pkg::mem_op_t      mem_op,
  output decode_pkg::sys_op_t      sys_op,
  output decode_pkg::branch_cond_t branch_cond
);
  import rv_isa_pkg::*;
  import decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       sys_fields_zero;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // ecall/ebreak need funct3, rs1 and rd all zero
  assign sys_fields_zero = funct3 == 3'b000 && instr[19:15] == 5'd0 && instr[11:7] == 5'd0;

  function automatic alu_op_t base_alu_op(input logic [2:0] f3);
    case (f3)
      f3_add:  return alu_add;
      f3_sll:  return alu_sll;
      f3_slt:  return alu_slt;
      f3_sltu: return alu_sltu;
      f3_xor:  return alu_xor;
      f3_sr:   return alu_srl;
      f3_or:   return alu_or;
      default: return alu_and;
    endcase
  endfunction

  function automatic alu_op_t muldiv_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return alu_mul;
      3'b001:  return alu_mulh;
      3'b010:  return alu_mulhsu;
      3'b011:  return alu_mulhu;
      3'b100:  return alu_div;
      3'b101:  return alu_divu;
      3'b110:  return alu_rem;
      default: return alu_remu;
    endcase
  endfunction

  always_comb begin
    instr_class = cls_illegal;
    alu_op      = alu_none;
    mem_op      = mem_none;
    sys_op      = sys_none;
    branch_cond = br_eq;
    case (opcode)
      opc_lui:   instr_class = cls_lui;
      opc_auipc: instr_class = cls_auipc;
      opc_jal:   instr_class = cls_jal;
      opc_jalr: begin
        if (funct3 == 3'b000)
          instr_class = cls_jalr;
      end
      opc_branch: begin
        // funct3 010 and 011 are reserved
        if (funct3[2:1] != 2'b01) begin
          instr_class = cls_branch;
          branch_cond = branch_cond_t'(funct3);
        end
      end
      opc_load: begin
        instr_class = cls_load;
        case (funct3)
          f3_byte:   mem_op = mem_lb;
          f3_half:   mem_op = mem_lh;
          f3_word:   mem_op = mem_lw;
          f3_byte_u: mem_op = mem_lbu;
          f3_half_u: mem_op = mem_lhu;
          default:   instr_class = cls_illegal;
        endcase
      end
      opc_store: begin
        instr_class = cls_store;
        case (funct3)
          f3_byte: mem_op = mem_sb;
          f3_half: mem_op = mem_sh;
          f3_word: mem_op = mem_sw;
          default: instr_class = cls_illegal;
        endcase
      end
      opc_op_imm: begin
        instr_class = cls_op_imm;
        // only shifts carry a funct7 in the immediate form
        if (funct3 == f3_sll) begin
          if (funct7 == funct7_base)
            alu_op = alu_sll;
          else
            instr_class = cls_illegal;
        end else if (funct3 == f3_sr) begin
          if (funct7 == funct7_base)
            alu_op = alu_srl;
          else if (funct7 == funct7_alt)
            alu_op = alu_sra;
          else
            instr_class = cls_illegal;
        end else begin
          alu_op = base_alu_op(funct3);
        end
      end
      opc_op: begin
        instr_class = cls_op;
        case (funct7)
          funct7_base:   alu_op = base_alu_op(funct3);
          funct7_muldiv: alu_op = muldiv_op(funct3);
          funct7_alt: begin
            if (funct3 == f3_add)
              alu_op = alu_sub;
            else if (funct3 == f3_sr)
              alu_op = alu_sra;
            else
              instr_class = cls_illegal;
          end
          default: instr_class = cls_illegal;
        endcase
      end
      opc_system: begin
        if (sys_fields_zero && instr[31:21] == 11'd0) begin
          instr_class = cls_system;
          sys_op      = instr[20] ? sys_ebreak : sys_ecall;
        end
      end
      default: instr_class = cls_illegal;
    endcase
  end

endmodule

`default_nettype wire

/* hw/imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  rv_isa_pkg::word_t        instr,
  input  decode_pkg::instr_class_t instr_class,
  output rv_isa_pkg::word_t        imm
);
  import rv_isa_pkg::*;
  import decode_pkg::*;

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
  assign imm_s = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};

  // b and j are scrambled, bit 0 always zero
  assign imm_b = {{(xlen-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                  instr[11:8], 1'b0};
  assign imm_j = {{(xlen-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                  instr[30:21], 1'b0};

  assign imm_u = {instr[31:12], 12'b0};

  always_comb begin
    case (instr_class)
      cls_load, cls_jalr, cls_op_imm: imm = imm_i;
      cls_store:                      imm = imm_s;
      cls_branch:                     imm = imm_b;
      cls_lui, cls_auipc:             imm = imm_u;
      cls_jal:                        imm = imm_j;
      default:                        imm = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  decode_pkg::instr_class_t instr_class,
  input  decode_pkg::branch_cond_t branch_cond,
  input  rv_isa_pkg::word_t        imm,
  input  rv_isa_pkg::word_t        fetch_pc,
  input  rv_isa_pkg::word_t        reg_rs1_data,
  input  rv_isa_pkg::word_t        reg_rs2_data,
  output rv_isa_pkg::word_t        next_pc
);
  import rv_isa_pkg::*;
  import decode_pkg::*;

  logic  eq;
  logic  lt_s;
  logic  lt_u;
  logic  taken;
  word_t seq_pc;
  word_t rel_target;
  word_t ind_sum;
  word_t pc_d;

  assign eq   = reg_rs1_data == reg_rs2_data;
  assign lt_s = $signed(reg_rs1_data) < $signed(reg_rs2_data);
  assign lt_u = reg_rs1_data < reg_rs2_data;

  always_comb begin
    case (branch_cond)
      br_eq:   taken = eq;
      br_ne:   taken = !eq;
      br_lt:   taken = lt_s;
      br_ge:   taken = !lt_s;
      br_ltu:  taken = lt_u;
      br_geu:  taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

  assign seq_pc     = fetch_pc + instr_bytes;
  assign rel_target = fetch_pc + imm;
  assign ind_sum    = reg_rs1_data + imm;

  always_comb begin
    case (instr_class)
      cls_jal:    pc_d = rel_target;
      // jalr drops bit 0 of the sum
      cls_jalr:   pc_d = {ind_sum[xlen-1:1], 1'b0};
      cls_branch: pc_d = taken ? rel_target : seq_pc;
      default:    pc_d = seq_pc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset)
      next_pc <= '0;
    else
      next_pc <= pc_d;
  end

endmodule

`default_nettype wire

/* hw/operand_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
  input  logic                     clk,
  input  logic                     reset,
  input  rv_isa_pkg::word_t        instr,
  input  decode_pkg::instr_class_t instr_class,
  input  decode_pkg::alu_op_t      alu_op,
  input  decode_pkg::mem_op_t      mem_op,
  input  decode_pkg::sys_op_t      sys_op,
  input  rv_isa_pkg::word_t        imm,
  input  rv_isa_pkg::word_t        fetch_pc,
  input  rv_isa_pkg::word_t        reg_rs1_data,
  input  rv_isa_pkg::word_t        reg_rs2_data,
  output rv_isa_pkg::reg_idx_t     rs1,
  output rv_isa_pkg::reg_idx_t     rs2,
  output rv_isa_pkg::reg_idx_t     rd,
  output rv_isa_pkg::word_t        operand_a,
  output rv_isa_pkg::word_t        operand_b,
  output rv_isa_pkg::word_t        mem_addr,
  output decode_pkg::alu_op_t      alu_out_op,
  output decode_pkg::mem_op_t      mem_out_op,
  output decode_pkg::sys_op_t      sys_out_op,
  output logic                     instr_valid
);
  import rv_isa_pkg::*;
  import decode_pkg::*;

  word_t    op_a_d;
  word_t    op_b_d;
  word_t    shamt;
  reg_idx_t rd_d;
  alu_op_t  alu_d;

  // register file is read combinationally in this cycle
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  assign shamt = {{(xlen-5){1'b0}}, instr[24:20]};

  always_comb begin
    op_a_d = reg_rs1_data;
    op_b_d = reg_rs2_data;
    alu_d  = alu_op;
    rd_d   = instr[11:7];
    case (instr_class)
      cls_op_imm: begin
        op_b_d = (alu_op inside {alu_sll, alu_srl, alu_sra}) ? shamt : imm;
      end
      cls_lui: begin
        op_a_d = imm;
        op_b_d = '0;
        alu_d  = alu_add;
      end
      cls_auipc: begin
        op_a_d = fetch_pc;
        op_b_d = imm;
        alu_d  = alu_add;
      end
      // link value is pc + 4
      cls_jal, cls_jalr: begin
        op_a_d = fetch_pc;
        op_b_d = instr_bytes;
        alu_d  = alu_add;
      end
      cls_branch: begin
        op_a_d = '0;
        op_b_d = '0;
        rd_d   = '0;
      end
      cls_load: alu_d = alu_add;
      cls_store: begin
        alu_d = alu_add;
        rd_d  = '0;
      end
      cls_illegal: rd_d = '0;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      operand_a   <= '0;
      operand_b   <= '0;
      mem_addr    <= '0;
      rd          <= '0;
      alu_out_op  <= alu_none;
      mem_out_op  <= mem_none;
      sys_out_op  <= sys_none;
      instr_valid <= 1'b0;
    end else begin
      operand_a   <= op_a_d;
      operand_b   <= op_b_d;
      mem_addr    <= reg_rs1_data + imm;
      rd          <= rd_d;
      alu_out_op  <= alu_d;
      mem_out_op  <= mem_op;
      sys_out_op  <= sys_op;
      instr_valid <= instr_class != cls_illegal;
    end
  end

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  rv_isa_pkg::word_t    instr,
  input  rv_isa_pkg::word_t    fetch_pc,
  input  rv_isa_pkg::word_t    reg_rs1_data,
  input  rv_isa_pkg::word_t    reg_rs2_data,
  output rv_isa_pkg::reg_idx_t rs1,
  output rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::reg_idx_t rd,
  output rv_isa_pkg::word_t    next_pc,
  output rv_isa_pkg::word_t    operand_a,
  output rv_isa_pkg::word_t    operand_b,
  output rv_isa_pkg::word_t    mem_addr,
  output decode_pkg::alu_op_t  alu_op,
  output decode_pkg::mem_op_t  mem_op,
  output decode_pkg::sys_op_t  sys_op,
  output logic                 instr_valid
);
  import rv_isa_pkg::*;
  import decode_pkg::*;

  instr_class_t instr_class;
  alu_op_t      dec_alu_op;
  mem_op_t      dec_mem_op;
  sys_op_t      dec_sys_op;
  branch_cond_t branch_cond;
  word_t        imm;

  // combinational front
  instr_classifier u_classifier (
    .instr       (instr),
    .instr_class (instr_class),
    .alu_op      (dec_alu_op),
    .mem_op      (dec_mem_op),
    .sys_op      (dec_sys_op),
    .branch_cond (branch_cond)
  );

  imm_gen u_imm_gen (
    .instr       (instr),
    .instr_class (instr_class),
    .imm         (imm)
  );

  // registered back end
  branch_unit u_branch_unit (
    .clk          (clk),
    .reset        (reset),
    .instr_class  (instr_class),
    .branch_cond  (branch_cond),
    .imm          (imm),
    .fetch_pc     (fetch_pc),
    .reg_rs1_data (reg_rs1_data),
    .reg_rs2_data (reg_rs2_data),
    .next_pc      (next_pc)
  );

  operand_stage u_operand_stage (
    .clk          (clk),
    .reset        (reset),
    .instr        (instr),
    .instr_class  (instr_class),
    .alu_op       (dec_alu_op),
    .mem_op       (dec_mem_op),
    .sys_op       (dec_sys_op),
    .imm          (imm),
    .fetch_pc     (fetch_pc),
    .reg_rs1_data (reg_rs1_data),
    .reg_rs2_data (reg_rs2_data),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .mem_addr     (mem_addr),
    .alu_out_op   (alu_op),
    .mem_out_op   (mem_op),
    .sys_out_op   (sys_op),
    .instr_valid  (instr_valid)
  );

endmodule

`default_nettype wire

/* tests/decode_model.svh */
`ifndef decode_model_svh
`define decode_model_svh

// galois lfsr, one step per bit drawn
localparam logic [31:0] lfsr_taps = 32'h80200003;

logic [31:0] lfsr_state;

function automatic logic [31:0] draw_bits(input int unsigned count);
  logic [31:0] value;
  int unsigned k;
  value = '0;
  for (k = 0; k < count; k++) begin
    value = {value[30:0], lfsr_state[0]};
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? lfsr_taps : 32'h0);
  end
  return value;
endfunction

function automatic alu_op_t alu_base(input logic [2:0] f3);
  case (f3)
    3'b000:  return alu_add;
    3'b001:  return alu_sll;
    3'b010:  return alu_slt;
    3'b011:  return alu_sltu;
    3'b100:  return alu_xor;
    3'b101:  return alu_srl;
    3'b110:  return alu_or;
    default: return alu_and;
  endcase
endfunction

function automatic alu_op_t alu_muldiv(input logic [2:0] f3);
  case (f3)
    3'b000:  return alu_mul;
    3'b001:  return alu_mulh;
    3'b010:  return alu_mulhsu;
    3'b011:  return alu_mulhu;
    3'b100:  return alu_div;
    3'b101:  return alu_divu;
    3'b110:  return alu_rem;
    default: return alu_remu;
  endcase
endfunction

// expected bundle for one instruction
task automatic decode_reference(
  input  word_t    instr_w,
  input  word_t    pc,
  input  word_t    rs1_val,
  input  word_t    rs2_val,
  output word_t    npc,
  output word_t    op_a,
  output word_t    op_b,
  output word_t    addr,
  output reg_idx_t rd_idx,
  output alu_op_t  alu,
  output mem_op_t  mem,
  output sys_op_t  sys,
  output logic     valid
);
  logic [2:0] f3;
  logic [6:0] f7;
  word_t      imm_i;
  word_t      imm;
  logic       taken;
  f3 = instr_w[14:12];
  f7 = instr_w[31:25];
  imm_i = {{20{instr_w[31]}}, instr_w[31:20]};
  imm = '0;
  taken = 1'b0;
  valid = 1'b1;
  npc = pc + 32'd4;
  op_a = rs1_val;
  op_b = rs2_val;
  rd_idx = instr_w[11:7];
  alu = alu_none;
  mem = mem_none;
  sys = sys_none;
  case (instr_w[6:0])
    opc_lui: begin
      imm = {instr_w[31:12], 12'b0};
      op_a = imm;
      op_b = '0;
      alu = alu_add;
    end
    opc_auipc: begin
      imm = {instr_w[31:12], 12'b0};
      op_a = pc;
      op_b = imm;
      alu = alu_add;
    end
    opc_jal: begin
      imm = {{11{instr_w[31]}}, instr_w[31], instr_w[19:12], instr_w[20],
             instr_w[30:21], 1'b0};
      npc = pc + imm;
      op_a = pc;
      op_b = 32'd4;
      alu = alu_add;
    end
    opc_jalr: begin
      imm = imm_i;
      npc = (rs1_val + imm) & ~32'd1;
      op_a = pc;
      op_b = 32'd4;
      alu = alu_add;
      valid = f3 == 3'b000;
    end
    opc_branch: begin
      imm = {{19{instr_w[31]}}, instr_w[31], instr_w[7], instr_w[30:25],
             instr_w[11:8], 1'b0};
      op_a = '0;
      op_b = '0;
      rd_idx = '0;
      case (f3)
        3'b000:  taken = rs1_val == rs2_val;
        3'b001:  taken = rs1_val != rs2_val;
        3'b100:  taken = $signed(rs1_val) < $signed(rs2_val);
        3'b101:  taken = $signed(rs1_val) >= $signed(rs2_val);
        3'b110:  taken = rs1_val < rs2_val;
        3'b111:  taken = rs1_val >= rs2_val;
        default: valid = 1'b0;
      endcase
      if (taken)
        npc = pc + imm;
    end
    opc_load: begin
      imm = imm_i;
      alu = alu_add;
      case (f3)
        3'b000:  mem = mem_lb;
        3'b001:  mem = mem_lh;
        3'b010:  mem = mem_lw;
        3'b100:  mem = mem_lbu;
        3'b101:  mem = mem_lhu;
        default: valid = 1'b0;
      endcase
    end
    opc_store: begin
      imm = {{20{instr_w[31]}}, instr_w[31:25], instr_w[11:7]};
      alu = alu_add;
      rd_idx = '0;
      case (f3)
        3'b000:  mem = mem_sb;
        3'b001:  mem = mem_sh;
        3'b010:  mem = mem_sw;
        default: valid = 1'b0;
      endcase
    end
    opc_op_imm: begin
      imm = imm_i;
      op_b = imm;
      alu = alu_base(f3);
      // shifts take shamt and a restricted funct7
      if (f3 == 3'b001 || f3 == 3'b101) begin
        op_b = {27'b0, instr_w[24:20]};
        if (f3 == 3'b101 && f7 == funct7_alt)
          alu = alu_sra;
        else if (f7 != funct7_base)
          valid = 1'b0;
      end
    end
    opc_op: begin
      case (f7)
        funct7_base:   alu = alu_base(f3);
        funct7_muldiv: alu = alu_muldiv(f3);
        funct7_alt: begin
          if (f3 == 3'b000)
            alu = alu_sub;
          else if (f3 == 3'b101)
            alu = alu_sra;
          else
            valid = 1'b0;
        end
        default: valid = 1'b0;
      endcase
    end
    opc_system: begin
      if (instr_w == 32'h0000_0073)
        sys = sys_ecall;
      else if (instr_w == 32'h0010_0073)
        sys = sys_ebreak;
      else
        valid = 1'b0;
    end
    default: valid = 1'b0;
  endcase
  if (!valid) begin
    imm = '0;
    npc = pc + 32'd4;
    op_a = rs1_val;
    op_b = rs2_val;
    rd_idx = '0;
    alu = alu_none;
    mem = mem_none;
    sys = sys_none;
  end
  addr = rs1_val + imm;
endtask

`endif

/* tests/decode_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;
  import rv_isa_pkg::*;
  import decode_pkg::*;

  localparam int num_tests      = 3000;
  localparam int reset_cycles   = 3;
  localparam int timeout_cycles = num_tests + reset_cycles + 20;

  logic     clk;
  logic     reset;
  word_t    instr;
  word_t    fetch_pc;
  word_t    reg_rs1_data;
  word_t    reg_rs2_data;
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    next_pc;
  word_t    operand_a;
  word_t    operand_b;
  word_t    mem_addr;
  alu_op_t  alu_op;
  mem_op_t  mem_op;
  sys_op_t  sys_op;
  logic     instr_valid;

  // bundle expected one cycle after the inputs
  word_t    exp_next_pc;
  word_t    exp_operand_a;
  word_t    exp_operand_b;
  word_t    exp_mem_addr;
  reg_idx_t exp_rd;
  alu_op_t  exp_alu_op;
  mem_op_t  exp_mem_op;
  sys_op_t  exp_sys_op;
  logic     exp_valid;

  string       test_label;
  int unsigned cycle_count = 0;

  `include "decode_model.svh"

  decode_stage uut (
    .clk          (clk),
    .reset        (reset),
    .instr        (instr),
    .fetch_pc     (fetch_pc),
    .reg_rs1_data (reg_rs1_data),
    .reg_rs2_data (reg_rs2_data),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .next_pc      (next_pc),
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .mem_addr     (mem_addr),
    .alu_op       (alu_op),
    .mem_op       (mem_op),
    .sys_op       (sys_op),
    .instr_valid  (instr_valid)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("the run timed out after %0d cycles", timeout_cycles);
      stop_on_failure();
    end
  end

  task automatic stop_on_failure();
    $display("Some tests failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %h, actual %h", test_label, what, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic check_reg_idx(input string what, input reg_idx_t expected,
                               input reg_idx_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %0d, actual %0d", test_label, what, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic check_alu_op(input string what, input alu_op_t expected, input alu_op_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %s, actual %s", test_label, what,
               expected.name(), actual.name());
      stop_on_failure();
    end
  endtask

  task automatic check_mem_op(input string what, input mem_op_t expected, input mem_op_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %s, actual %s", test_label, what,
               expected.name(), actual.name());
      stop_on_failure();
    end
  endtask

  task automatic check_sys_op(input string what, input sys_op_t expected, input sys_op_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %s, actual %s", test_label, what,
               expected.name(), actual.name());
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %b, actual %b", test_label, what, expected, actual);
      stop_on_failure();
    end
  endtask

  function automatic logic [6:0] pick_funct7();
    logic [31:0] bits;
    bits = draw_bits(7);
    case (draw_bits(2))
      0:       return funct7_base;
      1:       return funct7_alt;
      2:       return funct7_muldiv;
      default: return bits[6:0];
    endcase
  endfunction

  // random class with random fields, one in eight a raw word
  task automatic apply_stimulus();
    word_t       word;
    int unsigned kind;
    word = draw_bits(32);
    if (draw_bits(3) != 0) begin
      kind = draw_bits(4) % 10;
      case (kind)
        0: word[6:0] = opc_lui;
        1: word[6:0] = opc_auipc;
        2: word[6:0] = opc_jal;
        3: begin
          word[6:0] = opc_jalr;
          if (draw_bits(2) != 0)
            word[14:12] = 3'b000;
        end
        4: word[6:0] = opc_branch;
        5: word[6:0] = opc_load;
        6: word[6:0] = opc_store;
        7: begin
          word[6:0] = opc_op_imm;
          if (word[13:12] == 2'b01)
            word[31:25] = pick_funct7();
        end
        8: begin
          word[6:0] = opc_op;
          word[31:25] = pick_funct7();
        end
        default: begin
          word[6:0] = opc_system;
          case (draw_bits(2))
            0:       word = 32'h0000_0073;
            1:       word = 32'h0010_0073;
            default: ;
          endcase
        end
      endcase
    end
    instr = word;
    fetch_pc = draw_bits(30) << 2;
    reg_rs1_data = draw_bits(32);
    // equal operands about one time in four
    reg_rs2_data = (draw_bits(2) == 0) ? reg_rs1_data : draw_bits(32);
    decode_reference(instr, fetch_pc, reg_rs1_data, reg_rs2_data, exp_next_pc,
                     exp_operand_a, exp_operand_b, exp_mem_addr, exp_rd, exp_alu_op,
                     exp_mem_op, exp_sys_op, exp_valid);
  endtask

  task automatic check_reset_state();
    check_word("next_pc", '0, next_pc);
    check_word("operand_a", '0, operand_a);
    check_word("operand_b", '0, operand_b);
    check_word("mem_addr", '0, mem_addr);
    check_reg_idx("rd", '0, rd);
    check_alu_op("alu_op", alu_none, alu_op);
    check_mem_op("mem_op", mem_none, mem_op);
    check_sys_op("sys_op", sys_none, sys_op);
    check_bit("instr_valid", 1'b0, instr_valid);
  endtask

  task automatic check_bundle();
    check_word("next_pc", exp_next_pc, next_pc);
    check_word("operand_a", exp_operand_a, operand_a);
    check_word("operand_b", exp_operand_b, operand_b);
    check_word("mem_addr", exp_mem_addr, mem_addr);
    check_reg_idx("rd", exp_rd, rd);
    check_alu_op("alu_op", exp_alu_op, alu_op);
    check_mem_op("mem_op", exp_mem_op, mem_op);
    check_sys_op("sys_op", exp_sys_op, sys_op);
    check_bit("instr_valid", exp_valid, instr_valid);
  endtask

  initial begin
    int unsigned n;
    clk = 1'b0;
    reset = 1'b1;
    instr = '0;
    fetch_pc = '0;
    reg_rs1_data = '0;
    reg_rs2_data = '0;
    lfsr_state = 32'd21;
    test_label = "reset";
    // inputs keep moving while reset holds the outputs
    repeat (reset_cycles) begin
      @(negedge clk);
      check_reset_state();
      apply_stimulus();
    end
    reset = 1'b0;
    for (n = 0; n <= num_tests; n++) begin
      if (n > 0)
        check_bundle();
      if (n < num_tests) begin
        apply_stimulus();
        test_label = $sformatf("instr %0d (%h)", n, instr);
        #1;
        check_reg_idx("rs1", instr[19:15], rs1);
        check_reg_idx("rs2", instr[24:20], rs2);
        @(negedge clk);
      end
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+tests
hw/rv_isa_pkg.sv
hw/decode_pkg.sv
hw/instr_classifier.sv
hw/imm_gen.sv
hw/branch_unit.sv
hw/operand_stage.sv
hw/decode_stage.sv
tests/decode_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module decode_stage_tb -o decode_sim

output=$(./obj_dir/decode_sim 2>&1) || true
echo "$output"

if grep -q "All tests passed" <<< "$output"; then
  exit 0
else
  exit 1
fi
